/* verilog.f */
common/aluOpPkg.sv
common/claPkg.sv
adder/claGroup.sv
adder/carryLookahead.sv
hw/aluInStage.sv
hw/aluOutStage.sv
hw/aluTop.sv
dv/aluTb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := aluTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
PASSTEXT  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* dv/aluTb.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTb;

	import aluOpPkg::*;

	localparam int TotalRequests = 356; // 4 tests of 64 plus 100 under back-pressure
	localparam int TimeoutCycles = 3 * TotalRequests + 200;
	localparam logic [31:0] LfsrSeed = 32'ha9b3_72c0;
	localparam logic [31:0] LfsrTaps = 32'h8020_0003;

	logic    clk = 1'b0;
	logic    rstN = 1'b0;
	logic    reqValid = 1'b0;
	logic    reqReady;
	aluReq_t req = '0;
	logic    rspValid;
	logic    rspReady = 1'b1;
	aluRsp_t rsp;

	logic [31:0] lfsrState = LfsrSeed;
	int          cycles = 0;
	int          errorCount = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	logic        reqTaken = 1'b0; // last driven request went in
	logic        heldValid = 1'b0; // response was stalled last cycle
	aluRsp_t     heldRsp = '0;
	logic        checkLatency = 1'b0;
	aluReq_t     stimQ[$];
	aluReq_t     modelQ[$];
	int          acceptQ[$];

	aluTop u_dut (
		.clk     (clk),
		.rstN    (rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req     (req),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rsp     (rsp)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LfsrTaps;
		end
		return s >> 1;
	endfunction

	function automatic logic randBit();
		lfsrState = lfsrStep(lfsrState);
		return lfsrState[0];
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], randBit()};
		end
		return v;
	endfunction

	function automatic aluReq_t makeReq(input aluOp_e op, input logic [31:0] a,
		input logic [31:0] b);
		aluReq_t r;
		r.op = op;
		r.a = a;
		r.b.data = b;
		return r;
	endfunction

	// expected response, built bit by bit from the operation rules
	function automatic aluRsp_t expectRsp(input aluReq_t r);
		aluRsp_t e;
		logic [DataWidth:0] wide;
		int amt;
		e.result = '0;
		e.carry = 1'b0;
		amt = int'(r.b.data[ShamtWidth-1:0]); // only the low five bits count
		case (r.op)
			opAdd: begin
				wide = {1'b0, r.a} + {1'b0, r.b.data};
				e.result = wide[DataWidth-1:0];
				e.carry = wide[DataWidth];
			end
			opShl: begin
				for (int i = amt; i < DataWidth; i++) begin
					e.result[i] = r.a[i - amt];
				end
			end
			opTrunc: begin
				for (int i = 0; i < amt; i++) begin
					e.result[i] = r.a[i]; // bits at or above amt stay zero
				end
			end
			opAnd: e.result = r.a & r.b.data;
			opOr: e.result = r.a | r.b.data;
			opNot: e.result = ~r.a;
			opXor: e.result = r.a ^ r.b.data;
			default: e.result = '0;
		endcase
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
		errorCount++;
	endtask

	task automatic reportError(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errorCount++;
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		reqValid = 1'b0;
		reqTaken = 1'b0;
		heldValid = 1'b0;
		repeat (16) @(negedge clk);
		rstN = 1'b1;
	endtask

	// both stages full and stalled so the reset has something to clear
	task automatic clogPipeline();
		rspReady = 1'b0;
		req = makeReq(opAdd, randBits(32), randBits(32));
		reqValid = 1'b1;
		repeat (3) @(negedge clk);
		assert (rspValid === 1'b1 && reqReady === 1'b0)
			else reportError("pipeline did not fill up under back-pressure before reset");
	endtask

	// drive on the falling edge, then sample what the next rising edge will transfer
	task automatic runCycle(input logic gaps, input logic stalls);
		aluReq_t sent;
		aluRsp_t want;
		int latency;
		@(negedge clk);
		if (!reqValid || reqTaken) begin
			if (stimQ.size() > 0 && (!gaps || randBit() == 1'b1)) begin
				req = stimQ.pop_front();
				reqValid = 1'b1;
			end else begin
				reqValid = 1'b0;
			end
		end
		rspReady = stalls ? randBit() : 1'b1;
		#1;
		if (heldValid) begin
			assert (rspValid === 1'b1) else reportError("stalled response was dropped");
			assert (rsp.result === heldRsp.result)
				else reportMismatch("rsp.result (stalled)", rsp.result, heldRsp.result);
			assert (rsp.carry === heldRsp.carry)
				else reportMismatch("rsp.carry (stalled)", 32'(rsp.carry), 32'(heldRsp.carry));
		end
		heldValid = rspValid && !rspReady;
		heldRsp = rsp;
		if (rspValid && rspReady) begin
			assert (modelQ.size() > 0) else reportError("response with no request outstanding");
			if (modelQ.size() > 0) begin
				sent = modelQ.pop_front();
				latency = cycles - acceptQ.pop_front();
				want = expectRsp(sent);
				assert (rsp.result === want.result)
					else reportMismatch("rsp.result", rsp.result, want.result);
				assert (rsp.carry === want.carry)
					else reportMismatch("rsp.carry", 32'(rsp.carry), 32'(want.carry));
				if (checkLatency) begin
					assert (latency == 2) else reportMismatch("latency", 32'(latency), 32'd2);
				end
			end
		end
		reqTaken = reqValid && reqReady;
		if (reqTaken) begin
			modelQ.push_back(req);
			acceptQ.push_back(cycles);
		end
	endtask

	task automatic runTest(input string name, input logic gaps, input logic stalls,
		input int startErrors);
		int count;
		count = stimQ.size();
		while (stimQ.size() > 0 || (reqValid && !reqTaken) || modelQ.size() > 0) begin
			runCycle(gaps, stalls);
		end
		@(negedge clk);
		reqValid = 1'b0;
		reqTaken = 1'b0;
		rspReady = 1'b1;
		if (errorCount == startErrors) begin
			$display("test %s: passed, %0d requests", name, count);
			testsPassed++;
		end else begin
			$display("test %s: failed, %0d errors", name, errorCount - startErrors);
			testsFailed++;
		end
	endtask

	task automatic fillArith();
		stimQ.push_back(makeReq(opAdd, 32'h0000_0000, 32'h0000_0000));
		stimQ.push_back(makeReq(opAdd, 32'hffff_ffff, 32'h0000_0001));
		stimQ.push_back(makeReq(opAdd, 32'hffff_ffff, 32'hffff_ffff));
		stimQ.push_back(makeReq(opAdd, 32'h8000_0000, 32'h8000_0000));
		repeat (60) stimQ.push_back(makeReq(opAdd, randBits(32), randBits(32)));
	endtask

	task automatic fillShift();
		aluOp_e op;
		stimQ.push_back(makeReq(opTrunc, 32'h1234_5678, 32'hffff_ffe0)); // amount 0
		stimQ.push_back(makeReq(opShl, 32'hdead_beef, 32'h0000_0000));
		stimQ.push_back(makeReq(opShl, 32'h0000_0003, 32'hffff_ff1f));
		stimQ.push_back(makeReq(opTrunc, 32'hffff_ffff, 32'h8000_001f));
		repeat (60) begin
			op = randBit() ? opShl : opTrunc;
			stimQ.push_back(makeReq(op, randBits(32), randBits(32)));
		end
	endtask

	task automatic fillLogic();
		logic [31:0] pick;
		aluOp_e op;
		stimQ.push_back(makeReq(opNone, 32'hffff_ffff, 32'hffff_ffff));
		stimQ.push_back(makeReq(opNot, 32'h0000_0000, 32'hffff_ffff));
		stimQ.push_back(makeReq(opXor, 32'ha5a5_a5a5, 32'hffff_ffff));
		stimQ.push_back(makeReq(opAnd, 32'hffff_ffff, 32'h0f0f_0f0f));
		repeat (60) begin
			pick = randBits(8) % 5;
			op = aluOp_e'(3'(pick + 3)); // opAnd up to opNone
			stimQ.push_back(makeReq(op, randBits(32), randBits(32)));
		end
	endtask

	task automatic fillMixed(input int n);
		logic [31:0] pick;
		repeat (n) begin
			pick = randBits(3);
			stimQ.push_back(makeReq(aluOp_e'(pick[2:0]), randBits(32), randBits(32)));
		end
	endtask

	initial begin
		int startErrors;
		applyReset();
		fillArith();
		runTest("arithmetic and carry", 1'b0, 1'b0, errorCount);
		fillShift();
		runTest("shift and truncation", 1'b0, 1'b0, errorCount);
		fillLogic();
		runTest("logic and unused code", 1'b0, 1'b0, errorCount);
		startErrors = errorCount;
		clogPipeline();
		applyReset();
		#1;
		assert (rspValid === 1'b0) else reportMismatch("rspValid", 32'(rspValid), 32'd0);
		assert (reqReady === 1'b1) else reportMismatch("reqReady", 32'(reqReady), 32'd1);
		fillMixed(64);
		checkLatency = 1'b1;
		runTest("reset and pipelining", 1'b0, 1'b0, startErrors);
		checkLatency = 1'b0;
		fillMixed(100);
		runTest("back-pressure", 1'b1, 1'b1, errorCount);
		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/aluTop.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTop #(
	parameter int GroupWidth = claPkg::DefaultGroupWidth
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic              reqValid,
	output logic              reqReady,
	input  aluOpPkg::aluReq_t req,
	output logic              rspValid,
	input  logic              rspReady,
	output aluOpPkg::aluRsp_t rsp
);

	import aluOpPkg::*;
	import claPkg::*;

	localparam int NumGroups = DataWidth / GroupWidth;

	logic                   stageValid;
	logic                   stageReady;
	aluReq_t                stageReq;
	groupPg_t [NumGroups-1:0] groupPg;
	logic [NumGroups-1:0]   groupCarryIn;
	logic [DataWidth-1:0]   sum;
	logic                   carryOut;

	aluInStage u_inStage (
		.clk       (clk),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqReady  (reqReady),
		.req       (req),
		.stageValid(stageValid),
		.stageReady(stageReady),
		.stageReq  (stageReq)
	);

	for (genvar i = 0; i < NumGroups; i++) begin : gGroup
		claGroup #(
			.GroupWidth(GroupWidth)
		) u_group (
			.a      (stageReq.a[i*GroupWidth +: GroupWidth]),
			.b      (stageReq.b.data[i*GroupWidth +: GroupWidth]),
			.carryIn(groupCarryIn[i]),
			.pg     (groupPg[i]),
			.sum    (sum[i*GroupWidth +: GroupWidth])
		);
	end

	carryLookahead #(
		.GroupWidth(GroupWidth)
	) u_lookahead (
		.pg      (groupPg),
		.carryIn (groupCarryIn),
		.carryOut(carryOut)
	);

	aluOutStage u_outStage (
		.clk       (clk),
		.rstN      (rstN),
		.stageValid(stageValid),
		.stageReady(stageReady),
		.stageReq  (stageReq),
		.sum       (sum),
		.carryOut  (carryOut),
		.rspValid  (rspValid),
		.rspReady  (rspReady),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

/* hw/aluOutStage.sv */
`timescale 1ns/10ps
`default_nettype none

module aluOutStage (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           stageValid,
	output logic                           stageReady,
	input  aluOpPkg::aluReq_t              stageReq,
	input  logic [aluOpPkg::DataWidth-1:0] sum,
	input  logic                           carryOut,
	output logic                           rspValid,
	input  logic                           rspReady,
	output aluOpPkg::aluRsp_t              rsp
);

	import aluOpPkg::*;

	logic [ShamtWidth-1:0] amount;
	logic [DataWidth-1:0]  shiftVal;
	logic [DataWidth-1:0]  truncMask;
	aluRsp_t               rspNext;
	logic                  capture;

	assign amount = stageReq.b.amt.shamt; // upper bits of b ignored
	assign shiftVal = stageReq.a << amount;
	assign truncMask = ~({DataWidth{1'b1}} << amount); // amount 0 keeps nothing

	always_comb begin
		rspNext.carry = 1'b0;
		case (stageReq.op)
			opAdd: begin
				rspNext.result = sum;
				rspNext.carry = carryOut;
			end
			opShl: rspNext.result = shiftVal;
			opTrunc: rspNext.result = stageReq.a & truncMask;
			opAnd: rspNext.result = stageReq.a & stageReq.b.data;
			opOr: rspNext.result = stageReq.a | stageReq.b.data;
			opNot: rspNext.result = ~stageReq.a;
			opXor: rspNext.result = stageReq.a ^ stageReq.b.data;
			default: rspNext.result = '0; // opNone
		endcase
	end

	// empty, or being drained this cycle
	assign stageReady = !rspValid || rspReady;
	assign capture = stageValid && stageReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rspValid <= 1'b0;
		end else if (stageReady) begin
			rspValid <= stageValid;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			rsp <= rspNext;
		end
	end

	// stalled response must not change
	rspStable: assert property (
		@(posedge clk) disable iff (!rstN)
		rspValid && !rspReady |=> $stable(rsp)
	);

	// a response only goes away once taken
	rspHeld: assert property (
		@(posedge clk) disable iff (!rstN)
		rspValid && !rspReady |=> rspValid
	);

endmodule

`default_nettype wire

/* hw/aluInStage.sv */
`timescale 1ns/10ps
`default_nettype none

module aluInStage (
	input  logic              clk,
	input  logic              rstN,
	input  logic              reqValid,
	output logic              reqReady,
	input  aluOpPkg::aluReq_t req,
	output logic              stageValid,
	input  logic              stageReady,
	output aluOpPkg::aluReq_t stageReq
);

	logic load;

	// free slot, or the held entry leaves this cycle
	assign reqReady = !stageValid || stageReady;
	assign load = reqValid && reqReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stageValid <= 1'b0;
		end else if (reqReady) begin
			stageValid <= reqValid; // drops when taken and nothing new
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			stageReq <= req;
		end
	end

	// a held entry always carries a defined op code into the result select
	opKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		stageValid |-> !$isunknown(stageReq.op)
	);

endmodule

`default_nettype wire

/* adder/carryLookahead.sv */
`timescale 1ns/10ps
`default_nettype none

module carryLookahead #(
	parameter int GroupWidth = claPkg::DefaultGroupWidth,
	localparam int NumGroups = aluOpPkg::DataWidth / GroupWidth
) (
	input  claPkg::groupPg_t [NumGroups-1:0] pg,
	output logic [NumGroups-1:0]             carryIn,
	output logic                             carryOut
);

	// group count is a multiple of four for group widths 2, 4 and 8
	localparam int BlockSize = 4;
	localparam int NumBlocks = NumGroups / BlockSize;

	logic [NumBlocks-1:0] blockP;
	logic [NumBlocks-1:0] blockG;
	logic [NumBlocks:0]   blockCarry;

	// block propagate/generate over four groups
	always_comb begin
		logic genAcc;
		logic propAcc;
		for (int k = 0; k < NumBlocks; k++) begin
			genAcc = 1'b0;
			propAcc = 1'b1;
			for (int j = BlockSize - 1; j >= 0; j--) begin
				genAcc = genAcc | (propAcc & pg[k*BlockSize + j].g);
				propAcc = propAcc & pg[k*BlockSize + j].p;
			end
			blockP[k] = propAcc;
			blockG[k] = genAcc;
		end
	end

	always_comb begin
		blockCarry[0] = 1'b0; // no carry into bit 0
		for (int k = 0; k < NumBlocks; k++) begin
			blockCarry[k+1] = blockG[k] | (blockP[k] & blockCarry[k]);
		end
	end

	assign carryOut = blockCarry[NumBlocks];

	// group carry-ins from the block carry and the groups below
	always_comb begin
		logic genAcc;
		logic propAcc;
		for (int k = 0; k < NumBlocks; k++) begin
			for (int i = 0; i < BlockSize; i++) begin
				genAcc = 1'b0;
				propAcc = 1'b1;
				for (int j = i - 1; j >= 0; j--) begin
					genAcc = genAcc | (propAcc & pg[k*BlockSize + j].g);
					propAcc = propAcc & pg[k*BlockSize + j].p;
				end
				carryIn[k*BlockSize + i] = genAcc | (propAcc & blockCarry[k]);
			end
		end
	end

endmodule

`default_nettype wire

/* adder/claGroup.sv */
`timescale 1ns/10ps
`default_nettype none

module claGroup #(
	parameter int GroupWidth = claPkg::DefaultGroupWidth
) (
	input  logic [GroupWidth-1:0] a,
	input  logic [GroupWidth-1:0] b,
	input  logic                  carryIn,
	output claPkg::groupPg_t      pg,
	output logic [GroupWidth-1:0] sum
);

	logic [GroupWidth-1:0] p;
	logic [GroupWidth-1:0] g;
	logic [GroupWidth-1:0] carry;

	assign p = a ^ b;
	assign g = a & b;

	// carry into bit i as a sum of products, no ripple
	always_comb begin
		logic genAcc;
		logic propAcc;
		for (int i = 0; i < GroupWidth; i++) begin
			genAcc = 1'b0;
			propAcc = 1'b1;
			for (int m = i - 1; m >= 0; m--) begin
				genAcc = genAcc | (propAcc & g[m]);
				propAcc = propAcc & p[m];
			end
			carry[i] = genAcc | (propAcc & carryIn);
		end
	end

	// group terms for the next lookahead level
	always_comb begin
		logic genAcc;
		logic propAcc;
		genAcc = 1'b0;
		propAcc = 1'b1;
		for (int m = GroupWidth - 1; m >= 0; m--) begin
			genAcc = genAcc | (propAcc & g[m]);
			propAcc = propAcc & p[m];
		end
		pg.p = propAcc;
		pg.g = genAcc;
	end

	assign sum = p ^ carry;

endmodule

`default_nettype wire

/* common/claPkg.sv */
`default_nettype none

package claPkg;

	localparam int DefaultGroupWidth = 4; // bits per adder group

	// propagate/generate pair of one adder group
	typedef struct packed {
		logic p;
		logic g;
	} groupPg_t;

endpackage

`default_nettype wire

/* common/aluOpPkg.sv */
`default_nettype none

package aluOpPkg;

	localparam int DataWidth = 32;
	localparam int ShamtWidth = 5;

	// encoding follows the original gate-level ALU
	typedef enum logic [2:0] {
		opAdd   = 3'd0,
		opShl   = 3'd1,
		opTrunc = 3'd2,
		opAnd   = 3'd3,
		opOr    = 3'd4,
		opNot   = 3'd5,
		opXor   = 3'd6,
		opNone  = 3'd7 // result forced to zero
	} aluOp_e;

	typedef struct packed {
		logic [DataWidth-ShamtWidth-1:0] unused;
		logic [ShamtWidth-1:0]           shamt; // shift or truncation amount
	} amtView_t;

	// operand b is either a data word or carries an amount in its low bits
	typedef union packed {
		logic [DataWidth-1:0] data;
		amtView_t             amt;
	} operandB_u;

	typedef struct packed {
		aluOp_e               op;
		logic [DataWidth-1:0] a;
		operandB_u            b;
	} aluReq_t;

	typedef struct packed {
		logic [DataWidth-1:0] result;
		logic                 carry; // adder carry out, zero for other ops
	} aluRsp_t;

endpackage

`default_nettype wire
